/* src.f */
src/noc_flit_pkg.sv
src/noc_topology_pkg.sv
src/vc_buffer.sv
src/switch_allocator.sv
src/switch.sv
src/switch_wrapper.sv
testbench/tb_noc_checks.sv
testbench/tb_switch_wrapper.sv

/* Makefile */
TOP = tb_switch_wrapper
LOG = sim.log

all: run

build:
	verilator --binary --assert -Wno-fatal -j 0 -f src.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

/* testbench/tb_switch_wrapper.sv */
`timescale 1ns/1ps

module tb_switch_wrapper;
    localparam int     BUFFER_SIZE = 8;
    localparam int     NUM_RANDOM  = 240;
    localparam int     NUM_STALL   = 24;
    localparam int     NUM_FLITS   = 12 + NUM_RANDOM + NUM_STALL;
    localparam int     MAX_LATENCY = 8;     // four switches
    localparam longint TIMEOUT_NS  = 64'(40 * NUM_FLITS * MAX_LATENCY + 500) * 100;

    logic                clk = 1'b0;
    logic                rst_n;
    noc_flit_pkg::flit_t in_flit          [3:0];
    logic                data_ready_in    [3:0];
    logic                packet_sent      [3:0];
    noc_flit_pkg::flit_t out              [3:0];
    logic                data_ready_out   [3:0];
    logic                buffer_available [7:0];
    logic                idle_phase;
    logic                final_check;
    int                  pending;
    int                  check_errors;
    int                  tb_errors;
    int                  credits [4][2];    // endpoint side, per vc
    logic [3:0]          next_seq [4];
    integer              seed;

    always #50 clk = ~clk;

    switch_wrapper u_dut (.*);

    tb_noc_checks #(.BUFFER_SIZE(BUFFER_SIZE)) u_checks (.*, .errors(check_errors));

    // every cycle passes through here, so credit pulses are never missed
    task automatic step();
        @(negedge clk);
        for (int n = 0; n < 4; n++) begin
            data_ready_in[n] = 1'b0;
            for (int v = 0; v < 2; v++) begin
                if (buffer_available[v * 4 + n])
                    credits[n][v]++;
            end
        end
    endtask

    task automatic inject(input int n, input int d, input int v);
        noc_flit_pkg::flit_t f;
        f.metadata.dest  = noc_flit_pkg::node_id_t'(d);
        f.metadata.src   = noc_flit_pkg::node_id_t'(n);
        f.metadata.vc    = noc_flit_pkg::vc_id_t'(v);
        f.metadata.seq   = next_seq[n];
        f.payload        = $random(seed);
        in_flit[n]       = f;
        data_ready_in[n] = 1'b1;
        credits[n][v]--;
        next_seq[n]++;
    endtask

    task automatic drain(input int max_cycles);
        int c;
        c = 0;
        while (pending != 0 && c < max_cycles) begin
            step();
            c++;
        end
        if (pending != 0) begin
            tb_errors++;
            $display("network did not drain within %0d cycles", max_cycles);
        end
    endtask

    // stall sends everything to node 3 and keeps its endpoint from accepting
    task automatic traffic(input int count, input logic stall);
        int d;
        int v;
        int done;
        done = 0;
        while (done < count) begin
            for (int n = 0; n < 4; n++) begin
                d = stall ? 2 : (n + 1 + int'(($random(seed) & 32'hff) % 3)) % 4;
                v = $random(seed) & 1;
                if (done < count && d != n && credits[n][v] > 0 && ($random(seed) & 1)) begin
                    inject(n, d, v);
                    done++;
                end
                packet_sent[n] = stall ? (n != 2) : (($random(seed) & 3) != 0);
            end
            step();
        end
    endtask

    initial begin
        seed        = 32'h7831_6a93;
        rst_n       = 1'b0;
        idle_phase  = 1'b0;
        final_check = 1'b0;
        tb_errors   = 0;
        for (int n = 0; n < 4; n++) begin
            in_flit[n]       = '0;
            data_ready_in[n] = 1'b0;
            packet_sent[n]   = 1'b1;
            next_seq[n]      = '0;
            credits[n]       = '{BUFFER_SIZE, BUFFER_SIZE};
        end
        repeat (2) step();
        rst_n = 1'b1;
        repeat (4) step();          // quiet cycles after reset
        idle_phase = 1'b1;
        for (int s = 0; s < 4; s++) begin
            for (int d = 0; d < 4; d++) begin
                if (s != d) begin
                    inject(s, d, $random(seed) & 1);
                    step();
                    drain(20);
                end
            end
        end
        idle_phase = 1'b0;
        traffic(NUM_RANDOM, 1'b0);
        packet_sent = '{4{1'b1}};
        drain(500);
        traffic(NUM_STALL, 1'b1);
        repeat (16) step();         // let the backlog reach the endpoints
        packet_sent[2] = 1'b1;
        drain(500);
        final_check = 1'b1;
        step();
        final_check = 1'b0;
        for (int n = 0; n < 4; n++) begin
            for (int v = 0; v < 2; v++) begin
                assert (credits[n][v] == BUFFER_SIZE) else begin
                    tb_errors++;
                    $display("mismatch credits[%0d][%0d] got %h exp %h", n, v, credits[n][v],
                             BUFFER_SIZE);
                end
            end
        end
        $display("errors: %0d from checks, %0d from testbench", check_errors, tb_errors);
        if (check_errors == 0 && tb_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns with %0d flits in flight", TIMEOUT_NS, pending);
        $display("sim failed");
        $finish;
    end

endmodule

/* testbench/tb_noc_checks.sv */
`timescale 1ns/1ps

module tb_noc_checks #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  noc_flit_pkg::flit_t in_flit          [3:0],
    input  logic                data_ready_in    [3:0],
    input  logic                packet_sent      [3:0],
    input  noc_flit_pkg::flit_t out              [3:0],
    input  logic                data_ready_out   [3:0],
    input  logic                buffer_available [7:0],
    input  logic                idle_phase,     // network otherwise empty
    input  logic                final_check,
    output int                  pending,
    output int                  errors
);
    typedef struct packed {
        noc_flit_pkg::flit_t flit;
        logic [31:0]         stamp;     // cycle of the injection edge
    } sb_entry_t;

    // two cycles per switch on the route, [src][dest]
    localparam int LATENCY [4][4] = '{'{2, 8, 4, 6}, '{8, 2, 4, 6}, '{6, 6, 2, 4}, '{4, 4, 6, 2}};

    sb_entry_t           sb_q [32][$];  // src * 8 + dest * 2 + injected vc
    int                  outstanding [4][2];
    int                  cycle = 0;
    int                  since_rst = 0;
    logic                hold [4];
    noc_flit_pkg::flit_t held [4];

    // last link is 4 -> 1, or 1 -> 3 for a flit that started at node 4
    function automatic logic delivered_vc(input int s, input int d);
        return (d == 0) || (s == 3 && d == 2);
    endfunction

    initial errors = 0;

    always @(posedge clk) begin
        sb_entry_t                e;
        noc_flit_pkg::flit_meta_t exp_meta;
        int                       src;
        int                       k;
        cycle++;
        if (!rst_n) begin
            since_rst = 0;
            pending   = 0;
            for (int n = 0; n < 4; n++) begin
                hold[n]        = 1'b0;
                outstanding[n] = '{0, 0};
            end
        end else begin
            since_rst++;
            for (int n = 0; n < 4; n++) begin
                if (since_rst <= 3) begin
                    assert (data_ready_out[n] == 1'b0) else begin
                        errors++;
                        $display("mismatch data_ready_out[%0d] got %h exp 0", n, data_ready_out[n]);
                    end
                    assert (!buffer_available[n] && !buffer_available[n + 4]) else begin
                        errors++;
                        $display("mismatch buffer_available[%0d] got %h%h exp 00", n,
                                 buffer_available[n + 4], buffer_available[n]);
                    end
                end
                for (int w = 0; w < 2; w++) begin
                    if (buffer_available[w * 4 + n]) begin
                        assert (outstanding[n][w] > 0) else begin
                            errors++;
                            $display("node %0d returned a vc %0d credit it did not owe", n + 1, w);
                        end
                        outstanding[n][w]--;
                    end
                end
                if (data_ready_in[n]) begin
                    k = int'(in_flit[n].metadata.vc);
                    outstanding[n][k]++;
                    e.flit  = in_flit[n];
                    e.stamp = cycle;
                    sb_q[n * 8 + int'(in_flit[n].metadata.dest) * 2 + k].push_back(e);
                    pending++;
                end
                if (data_ready_out[n] && packet_sent[n]) begin
                    src = -1;
                    for (int s = 0; s < 4; s++) begin
                        for (int w = 0; w < 2; w++) begin
                            k = s * 8 + n * 2 + w;
                            if (src < 0 && sb_q[k].size() != 0 &&
                                sb_q[k][0].flit.payload == out[n].payload) begin
                                e   = sb_q[k].pop_front();
                                src = s;
                            end
                        end
                    end
                    assert (src >= 0) else begin
                        errors++;
                        $display("node %0d ejected payload %h out of order or never sent there",
                                 n + 1, out[n].payload);
                    end
                    if (src >= 0) begin
                        pending--;
                        exp_meta    = e.flit.metadata;
                        exp_meta.vc = delivered_vc(src, n);
                        assert (out[n].metadata == exp_meta) else begin
                            errors++;
                            $display("mismatch out[%0d].metadata got %h exp %h", n,
                                     out[n].metadata, exp_meta);
                        end
                        if (idle_phase) begin
                            assert (cycle - int'(e.stamp) == LATENCY[src][n]) else begin
                                errors++;
                                $display("mismatch latency of out[%0d] got %h exp %h", n,
                                         cycle - int'(e.stamp), LATENCY[src][n]);
                            end
                        end
                    end
                end
                if (hold[n]) begin  // refused last cycle, must still be offered
                    assert (data_ready_out[n] && out[n] == held[n]) else begin
                        errors++;
                        $display("mismatch out[%0d] while held got %h/%h exp %h/1", n,
                                 out[n], data_ready_out[n], held[n]);
                    end
                end
                hold[n] = data_ready_out[n] && !packet_sent[n];
                held[n] = out[n];
            end
            if (final_check) begin
                assert (pending == 0) else begin
                    errors++;
                    $display("%0d flits were never delivered", pending);
                end
                for (int n = 0; n < 4; n++) begin
                    for (int w = 0; w < 2; w++) begin
                        assert (outstanding[n][w] == 0) else begin
                            errors++;
                            $display("node %0d vc %0d never returned %0d credits", n + 1, w,
                                     outstanding[n][w]);
                        end
                    end
                end
            end
        end
    end

endmodule

/* src/switch_wrapper.sv */
`timescale 1ns/1ps

module switch_wrapper (
    input  logic                clk,
    input  logic                rst_n,
    input  noc_flit_pkg::flit_t in_flit          [3:0],
    input  logic                data_ready_in    [3:0],
    input  logic                packet_sent      [3:0],
    output noc_flit_pkg::flit_t out              [3:0],
    output logic                data_ready_out   [3:0],
    output logic                buffer_available [7:0]
);
    localparam int BUFFER_SIZE = 8;

    // per switch outputs, port 0 is the endpoint side
    noc_flit_pkg::flit_t [1:0]    sw1_out;
    noc_flit_pkg::flit_t [1:0]    sw2_out;
    noc_flit_pkg::flit_t [1:0]    sw3_out;
    noc_flit_pkg::flit_t [2:0]    sw4_out;
    logic [1:0]                   sw1_dro;
    logic [1:0]                   sw2_dro;
    logic [1:0]                   sw3_dro;
    logic [2:0]                   sw4_dro;
    noc_flit_pkg::vc_mask_t [1:0] sw1_ba;
    noc_flit_pkg::vc_mask_t [1:0] sw2_ba;
    noc_flit_pkg::vc_mask_t [2:0] sw3_ba;
    noc_flit_pkg::vc_mask_t [1:0] sw4_ba;

    switch #(.NODE(1), .NUM_INPORTS(2), .NUM_OUTPORTS(2), .BUFFER_SIZE(BUFFER_SIZE)) switch1 (
        .clk(clk), .rst_n(rst_n),
        .in              ({sw4_out[1], in_flit[0]}),          // port 1 from node 4
        .data_ready_in   ({sw4_dro[1], data_ready_in[0]}),
        .buffer_available(sw1_ba),
        .credit_granted  (sw3_ba[1]),
        .packet_sent     (packet_sent[0]),
        .out             (sw1_out),
        .data_ready_out  (sw1_dro)
    );

    switch #(.NODE(2), .NUM_INPORTS(2), .NUM_OUTPORTS(2), .BUFFER_SIZE(BUFFER_SIZE)) switch2 (
        .clk(clk), .rst_n(rst_n),
        .in              ({sw4_out[2], in_flit[1]}),
        .data_ready_in   ({sw4_dro[2], data_ready_in[1]}),
        .buffer_available(sw2_ba),
        .credit_granted  (sw3_ba[2]),
        .packet_sent     (packet_sent[1]),
        .out             (sw2_out),
        .data_ready_out  (sw2_dro)
    );

    switch #(.NODE(3), .NUM_INPORTS(3), .NUM_OUTPORTS(2), .BUFFER_SIZE(BUFFER_SIZE)) switch3 (
        .clk(clk), .rst_n(rst_n),
        .in              ({sw2_out[1], sw1_out[1], in_flit[2]}),
        .data_ready_in   ({sw2_dro[1], sw1_dro[1], data_ready_in[2]}),
        .buffer_available(sw3_ba),
        .credit_granted  (sw4_ba[1]),
        .packet_sent     (packet_sent[2]),
        .out             (sw3_out),
        .data_ready_out  (sw3_dro)
    );

    switch #(.NODE(4), .NUM_INPORTS(2), .NUM_OUTPORTS(3), .BUFFER_SIZE(BUFFER_SIZE)) switch4 (
        .clk(clk), .rst_n(rst_n),
        .in              ({sw3_out[1], in_flit[3]}),
        .data_ready_in   ({sw3_dro[1], data_ready_in[3]}),
        .buffer_available(sw4_ba),
        .credit_granted  ({sw2_ba[1], sw1_ba[1]}),             // ports 2 and 1
        .packet_sent     (packet_sent[3]),
        .out             (sw4_out),
        .data_ready_out  (sw4_dro)
    );

    assign out[0] = sw1_out[0];
    assign out[1] = sw2_out[0];
    assign out[2] = sw3_out[0];
    assign out[3] = sw4_out[0];

    assign data_ready_out[0] = sw1_dro[0];
    assign data_ready_out[1] = sw2_dro[0];
    assign data_ready_out[2] = sw3_dro[0];
    assign data_ready_out[3] = sw4_dro[0];

    // vc 0 pulses in the low nibble, vc 1 in the high one
    assign buffer_available[0] = sw1_ba[0][0];
    assign buffer_available[1] = sw2_ba[0][0];
    assign buffer_available[2] = sw3_ba[0][0];
    assign buffer_available[3] = sw4_ba[0][0];
    assign buffer_available[4] = sw1_ba[0][1];
    assign buffer_available[5] = sw2_ba[0][1];
    assign buffer_available[6] = sw3_ba[0][1];
    assign buffer_available[7] = sw4_ba[0][1];

endmodule

/* src/switch.sv */
`timescale 1ns/1ps

module switch #(
    parameter int NODE         = 1,
    parameter int NUM_INPORTS  = 2,
    parameter int NUM_OUTPORTS = 2,
    parameter int BUFFER_SIZE  = 8
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  noc_flit_pkg::flit_t [NUM_INPORTS-1:0]      in,
    input  logic [NUM_INPORTS-1:0]                     data_ready_in,
    output noc_flit_pkg::vc_mask_t [NUM_INPORTS-1:0]   buffer_available,
    input  noc_flit_pkg::vc_mask_t [NUM_OUTPORTS-1:1]  credit_granted,
    input  logic                                       packet_sent,
    output noc_flit_pkg::flit_t [NUM_OUTPORTS-1:0]     out,
    output logic [NUM_OUTPORTS-1:0]                    data_ready_out
);
    noc_flit_pkg::flit_t [NUM_INPORTS-1:0][noc_topology_pkg::NUM_VCS-1:0] heads;

    noc_flit_pkg::vc_mask_t [NUM_INPORTS-1:0] head_valid;
    noc_flit_pkg::vc_mask_t [NUM_INPORTS-1:0] pop;

    noc_flit_pkg::flit_t [NUM_OUTPORTS-1:0] grant_flit;
    logic [NUM_OUTPORTS-1:0]                grant_valid;
    logic [NUM_OUTPORTS-1:0]                out_busy;

    // one fifo pair per input port
    for (genvar i = 0; i < NUM_INPORTS; i++) begin : g_in
        vc_buffer #(
            .BUFFER_SIZE(BUFFER_SIZE)
        ) u_vc_buffer (
            .clk             (clk),
            .rst_n           (rst_n),
            .in_flit         (in[i]),
            .data_ready_in   (data_ready_in[i]),
            .pop             (pop[i]),
            .head            (heads[i]),
            .head_valid      (head_valid[i]),
            .buffer_available(buffer_available[i])
        );
    end

    switch_allocator #(
        .NODE        (NODE),
        .NUM_INPORTS (NUM_INPORTS),
        .NUM_OUTPORTS(NUM_OUTPORTS),
        .BUFFER_SIZE (BUFFER_SIZE)
    ) u_allocator (
        .clk        (clk),
        .rst_n      (rst_n),
        .heads      (heads),
        .head_valid (head_valid),
        .credit_in  (credit_granted),
        .out_busy   (out_busy),
        .pop        (pop),
        .grant_flit (grant_flit),
        .grant_valid(grant_valid)
    );

    // ejection stays occupied until the endpoint accepts
    always_comb begin
        out_busy    = '0;
        out_busy[0] = data_ready_out[0] && !packet_sent;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_ready_out <= '0;
        end else begin
            for (int o = 0; o < NUM_OUTPORTS; o++) begin
                if (!out_busy[o])
                    data_ready_out[o] <= grant_valid[o];  // network ports strobe once
            end
        end
    end

    // no grant on a busy output, so a held flit is never overwritten
    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_OUTPORTS; o++) begin
            if (grant_valid[o])
                out[o] <= grant_flit[o];
        end
    end

endmodule

/* src/switch_allocator.sv */
`timescale 1ns/1ps

module switch_allocator #(
    parameter int NODE         = 1,
    parameter int NUM_INPORTS  = 2,
    parameter int NUM_OUTPORTS = 2,
    parameter int BUFFER_SIZE  = 8
) (
    input  logic clk,
    input  logic rst_n,
    input  noc_flit_pkg::flit_t [NUM_INPORTS-1:0][noc_topology_pkg::NUM_VCS-1:0] heads,
    input  noc_flit_pkg::vc_mask_t [NUM_INPORTS-1:0]  head_valid,
    input  noc_flit_pkg::vc_mask_t [NUM_OUTPORTS-1:1] credit_in,
    input  logic [NUM_OUTPORTS-1:0]                    out_busy,
    output noc_flit_pkg::vc_mask_t [NUM_INPORTS-1:0]  pop,
    output noc_flit_pkg::flit_t [NUM_OUTPORTS-1:0]    grant_flit,
    output logic [NUM_OUTPORTS-1:0]                    grant_valid
);
    localparam int NUM_VCS = noc_topology_pkg::NUM_VCS;
    localparam int NUM_REQ = NUM_INPORTS * NUM_VCS;     // one requester per input fifo
    localparam int REQ_W   = $clog2(NUM_REQ);
    localparam int CNT_W   = $clog2(BUFFER_SIZE + 1);

    logic [noc_topology_pkg::PORT_W-1:0] req_port [NUM_INPORTS][NUM_VCS];
    noc_flit_pkg::vc_id_t                req_vc   [NUM_INPORTS][NUM_VCS];

    logic [CNT_W-1:0]   credits    [1:NUM_OUTPORTS-1][NUM_VCS];
    logic [NUM_VCS-1:0] has_credit [NUM_OUTPORTS];
    logic [NUM_REQ-1:0] eligible   [NUM_OUTPORTS];
    logic [REQ_W-1:0]   rr_ptr     [NUM_OUTPORTS];  // first requester to look at
    logic [REQ_W-1:0]   winner     [NUM_OUTPORTS];

    // route lookup and outgoing VC for every fifo head
    always_comb begin
        for (int i = 0; i < NUM_INPORTS; i++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                req_port[i][v] =
                    noc_topology_pkg::ROUTE_TABLE[NODE-1][heads[i][v].metadata.dest];
                req_vc[i][v] = noc_topology_pkg::dateline_vc(
                    NODE, i, int'(req_port[i][v]), noc_flit_pkg::vc_id_t'(v));
            end
        end
    end

    always_comb begin
        int k;
        has_credit[0] = '1;     // ejection is throttled by out_busy instead
        for (int o = 1; o < NUM_OUTPORTS; o++) begin
            for (int v = 0; v < NUM_VCS; v++)
                has_credit[o][v] = (credits[o][v] != '0);
        end
        for (int o = 0; o < NUM_OUTPORTS; o++) begin
            for (int i = 0; i < NUM_INPORTS; i++) begin
                for (int v = 0; v < NUM_VCS; v++) begin
                    k = i * NUM_VCS + v;
                    eligible[o][k] = head_valid[i][v] && (req_port[i][v] == o) &&
                                     !out_busy[o] && has_credit[o][req_vc[i][v]];
                end
            end
        end
    end

    // round-robin pick per output, starting at rr_ptr
    always_comb begin
        int   k;
        logic found;
        pop         = '0;
        grant_flit  = '0;
        grant_valid = '0;
        for (int o = 0; o < NUM_OUTPORTS; o++) begin
            found     = 1'b0;
            winner[o] = '0;
            for (int off = 0; off < NUM_REQ; off++) begin
                k = int'(rr_ptr[o]) + off;
                if (k >= NUM_REQ)
                    k = k - NUM_REQ;
                if (!found && eligible[o][k]) begin
                    found     = 1'b1;
                    winner[o] = REQ_W'(k);
                    grant_flit[o]             = heads[k / NUM_VCS][k % NUM_VCS];
                    grant_flit[o].metadata.vc = req_vc[k / NUM_VCS][k % NUM_VCS];
                    pop[k / NUM_VCS][k % NUM_VCS] = 1'b1;
                end
            end
            grant_valid[o] = found;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int o = 0; o < NUM_OUTPORTS; o++)
                rr_ptr[o] <= '0;
        end else begin
            for (int o = 0; o < NUM_OUTPORTS; o++) begin
                if (grant_valid[o])
                    rr_ptr[o] <= (winner[o] == REQ_W'(NUM_REQ - 1)) ?
                                 '0 : winner[o] + REQ_W'(1);
            end
        end
    end

    // credit counters of the network links, one per downstream fifo
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int o = 1; o < NUM_OUTPORTS; o++) begin
                for (int v = 0; v < NUM_VCS; v++)
                    credits[o][v] <= CNT_W'(BUFFER_SIZE);
            end
        end else begin
            for (int o = 1; o < NUM_OUTPORTS; o++) begin
                for (int v = 0; v < NUM_VCS; v++) begin
                    credits[o][v] <= credits[o][v] + CNT_W'(credit_in[o][v])
                        - CNT_W'(grant_valid[o] && (grant_flit[o].metadata.vc == v));
                end
            end
        end
    end

endmodule

/* src/vc_buffer.sv */
`timescale 1ns/1ps

module vc_buffer #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  noc_flit_pkg::flit_t                                in_flit,
    input  logic                                               data_ready_in,
    input  noc_flit_pkg::vc_mask_t                             pop,
    output noc_flit_pkg::flit_t [noc_topology_pkg::NUM_VCS-1:0] head,
    output noc_flit_pkg::vc_mask_t                             head_valid,
    output noc_flit_pkg::vc_mask_t                             buffer_available
);
    localparam int PTR_W = $clog2(BUFFER_SIZE);

    noc_flit_pkg::flit_t mem [noc_topology_pkg::NUM_VCS][BUFFER_SIZE];

    // extra msb tells full from empty
    logic [PTR_W:0] wr_ptr [noc_topology_pkg::NUM_VCS];
    logic [PTR_W:0] rd_ptr [noc_topology_pkg::NUM_VCS];

    noc_flit_pkg::vc_mask_t push;
    noc_flit_pkg::vc_mask_t pop_ok;

    always_comb begin
        for (int v = 0; v < noc_topology_pkg::NUM_VCS; v++) begin
            push[v]       = data_ready_in && (in_flit.metadata.vc == v);
            head_valid[v] = (wr_ptr[v] != rd_ptr[v]);
            head[v]       = mem[v][rd_ptr[v][PTR_W-1:0]];
        end
        pop_ok = pop & head_valid;  // never pop an empty fifo
    end

    always_ff @(posedge clk) begin
        for (int v = 0; v < noc_topology_pkg::NUM_VCS; v++) begin
            if (push[v])
                mem[v][wr_ptr[v][PTR_W-1:0]] <= in_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int v = 0; v < noc_topology_pkg::NUM_VCS; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
            end
        end else begin
            for (int v = 0; v < noc_topology_pkg::NUM_VCS; v++) begin
                if (push[v])
                    wr_ptr[v] <= wr_ptr[v] + (PTR_W + 1)'(1);
                if (pop_ok[v])
                    rd_ptr[v] <= rd_ptr[v] + (PTR_W + 1)'(1);
            end
        end
    end

    // one credit back upstream per freed slot
    always_ff @(posedge clk) begin
        if (!rst_n)
            buffer_available <= '0;
        else
            buffer_available <= pop_ok;
    end

endmodule

/* src/noc_topology_pkg.sv */
package noc_topology_pkg;

    localparam int NUM_NODES = 4;
    localparam int NUM_VCS   = 2;   // the dateline rule below needs exactly two
    localparam int MAX_PORTS = 3;   // node 3 inputs, node 4 outputs
    localparam int PORT_W    = $clog2(MAX_PORTS);

    // output port per current node (row) and destination (column)
    // port 0 is always the local endpoint
    localparam logic [PORT_W-1:0] ROUTE_TABLE [NUM_NODES][NUM_NODES] = '{
        '{2'd0, 2'd1, 2'd1, 2'd1},  // node 1
        '{2'd1, 2'd0, 2'd1, 2'd1},  // node 2
        '{2'd1, 2'd1, 2'd0, 2'd1},  // node 3
        '{2'd1, 2'd2, 2'd1, 2'd0}   // node 4
    };

    // the 4 -> 1 -> 3 path closes a dependency cycle, so it moves to VC 1
    localparam int DATELINE_NODE    = 4;    // leaving this node ...
    localparam int DATELINE_PORT    = 1;    // ... on this port, or entering on it
    localparam int DATELINE_IN_NODE = 1;    // ... at this node

    // outgoing VC of a flit from input in_port heading to out_port
    function automatic noc_flit_pkg::vc_id_t dateline_vc(
        input int                    node,
        input int                    in_port,
        input int                    out_port,
        input noc_flit_pkg::vc_id_t  in_vc
    );
        if (out_port == 0)
            return in_vc;           // ejection keeps the arrival VC
        if (node == DATELINE_NODE && out_port == DATELINE_PORT)
            return 1'b1;
        if (node == DATELINE_IN_NODE && in_port == DATELINE_PORT)
            return 1'b1;
        return 1'b0;
    endfunction

endpackage

/* src/noc_flit_pkg.sv */
package noc_flit_pkg;

    localparam int NODE_W    = 2;   // nodes 1..4 encoded 0..3
    localparam int SEQ_W     = 4;
    localparam int PAYLOAD_W = 32;

    typedef logic [NODE_W-1:0] node_id_t;

    typedef logic vc_id_t;          // two virtual channels

    // one bit per virtual channel, sized from the VC id
    typedef logic [(1 << $bits(vc_id_t))-1:0] vc_mask_t;

    // routing and ordering fields of a single-flit packet
    typedef struct packed {
        node_id_t         dest;
        node_id_t         src;
        vc_id_t           vc;       // rewritten at every hop
        logic [SEQ_W-1:0] seq;
    } flit_meta_t;

    typedef struct packed {
        flit_meta_t           metadata;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

endpackage
